// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= cpu_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
source/rv32i_pkg.sv
source/pipe_ctrl_if.sv
source/pipe_control.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/cpu_top.sv
verif/cpu_mem_model.sv
verif/cpu_tb.sv

// File: source/cpu_top.sv
/*
    RV32I five stage pipeline top
    stages, go/ready controller and the two memory ports
*/
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
    input  logic                       clk,
    input  logic                       rst,
    output logic                       imem_read,
    output logic [rv32i_pkg::XLEN-1:0] imem_addr,
    input  logic [rv32i_pkg::XLEN-1:0] imem_rdata,
    input  logic                       imem_resp,
    output logic                       dmem_read,
    output logic                       dmem_write,
    output logic [rv32i_pkg::XLEN-1:0] dmem_addr,
    output logic [rv32i_pkg::XLEN-1:0] dmem_wdata,
    input  logic [rv32i_pkg::XLEN-1:0] dmem_rdata,
    input  logic                       dmem_resp
);
    import rv32i_pkg::*;

    // fetch to decode
    logic [XLEN-1:0]   instr;
    rv32i_opcode       opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    control_word       cw;
    // decode to execute
    logic [XLEN-1:0]   rs1_val;
    logic [XLEN-1:0]   rs2_val;
    logic [XLEN-1:0]   imm;
    logic [REG_AW-1:0] rd;
    control_word       de_cw;
    // execute to memory
    logic [XLEN-1:0]   alu_out;
    logic [XLEN-1:0]   store_data;
    logic [REG_AW-1:0] ex_rd;
    control_word       ex_cw;
    // memory back to writeback in decode
    logic [REG_AW-1:0] wb_rd;
    logic [XLEN-1:0]   wb_data;
    logic              wb_write;

    pipe_ctrl_if pcif ();

    pipe_control u_ctrl (
        .clk    (clk),
        .rst    (rst),
        .ctrl   (pcif.ctrl),
        .opcode (opcode),
        .funct3 (funct3),
        .funct7 (funct7),
        .cw     (cw)
    );

    fetch_stage u_fetch (
        .clk        (clk),
        .rst        (rst),
        .pc         (pcif.stage),
        .imem_read  (imem_read),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .imem_resp  (imem_resp),
        .instr      (instr)
    );

    decode_stage u_decode (
        .clk      (clk),
        .rst      (rst),
        .pc       (pcif.stage),
        .instr    (instr),
        .opcode   (opcode),
        .funct3   (funct3),
        .funct7   (funct7),
        .cw       (cw),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .imm      (imm),
        .rd       (rd),
        .de_cw    (de_cw),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .wb_write (wb_write)
    );

    execute_stage u_execute (
        .clk        (clk),
        .rst        (rst),
        .pc         (pcif.stage),
        .de_cw      (de_cw),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .imm        (imm),
        .rd         (rd),
        .alu_out    (alu_out),
        .store_data (store_data),
        .ex_rd      (ex_rd),
        .ex_cw      (ex_cw)
    );

    memory_stage u_memory (
        .clk        (clk),
        .rst        (rst),
        .pc         (pcif.stage),
        .alu_out    (alu_out),
        .store_data (store_data),
        .ex_rd      (ex_rd),
        .ex_cw      (ex_cw),
        .dmem_read  (dmem_read),
        .dmem_write (dmem_write),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .dmem_resp  (dmem_resp),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .wb_write   (wb_write)
    );

endmodule

`default_nettype wire

// File: source/decode_stage.sv
/*
    Decode stage
    register file, operand read, immediate build, decode register
    and the writeback register that feeds the register file
*/
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                         clk,
    input  logic                         rst,
    pipe_ctrl_if.stage                   pc,
    input  logic [rv32i_pkg::XLEN-1:0]   instr,
    output rv32i_pkg::rv32i_opcode       opcode,
    output logic [2:0]                   funct3,
    output logic [6:0]                   funct7,
    input  rv32i_pkg::control_word       cw,
    output logic [rv32i_pkg::XLEN-1:0]   rs1_val,
    output logic [rv32i_pkg::XLEN-1:0]   rs2_val,
    output logic [rv32i_pkg::XLEN-1:0]   imm,
    output logic [rv32i_pkg::REG_AW-1:0] rd,
    output rv32i_pkg::control_word       de_cw,
    input  logic [rv32i_pkg::REG_AW-1:0] wb_rd,
    input  logic [rv32i_pkg::XLEN-1:0]   wb_data,
    input  logic                         wb_write
);
    import rv32i_pkg::*;

    logic [XLEN-1:0]   regs [REG_COUNT];
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [XLEN-1:0]   rs1_rd;
    logic [XLEN-1:0]   rs2_rd;
    logic [XLEN-1:0]   imm_next;
    logic              de_rdy_q;
    logic              wb_rdy_q;
    logic              wb_write_q;
    logic [REG_AW-1:0] wb_rd_q;
    logic [XLEN-1:0]   wb_data_q;

    // fields straight from the fetch register
    assign opcode = rv32i_opcode'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    // x0 reads zero
    assign rs1_rd = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_rd = (rs2 == '0) ? '0 : regs[rs2];

    always_comb begin
        if (opcode == op_store) begin
            // S-type offset split around rd
            imm_next = {{(XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
        end else begin
            imm_next = {{(XLEN-12){instr[31]}}, instr[31:20]};
        end
    end

    assign pc.de_rdy = de_rdy_q;
    assign pc.wb_rdy = wb_rdy_q;

    // decode register
    always_ff @(posedge clk) begin
        if (rst) begin
            de_cw    <= '0;
            de_rdy_q <= 1'b0;
        end else if (pc.de_go) begin
            de_cw    <= cw;
            de_rdy_q <= (cw.opcode != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (pc.de_go) begin
            rs1_val <= rs1_rd;
            rs2_val <= rs2_rd;
            imm     <= imm_next;
            rd      <= instr[11:7];
        end
    end

    // writeback register
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_rdy_q   <= 1'b0;
            wb_write_q <= 1'b0;
        end else if (pc.wb_go) begin
            wb_rdy_q   <= 1'b1;
            wb_write_q <= wb_write;
        end
    end

    always_ff @(posedge clk) begin
        if (pc.wb_go) begin
            wb_rd_q   <= wb_rd;
            wb_data_q <= wb_data;
        end
    end

    // register file write port
    // a held writeback just rewrites the same value
    always_ff @(posedge clk) begin
        if (wb_rdy_q && wb_write_q && (wb_rd_q != '0)) begin
            regs[wb_rd_q] <= wb_data_q;
        end
    end

endmodule

`default_nettype wire

// File: source/execute_stage.sv
/*
    Execute stage
    operand select, ALU and the execute register
*/
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                         clk,
    input  logic                         rst,
    pipe_ctrl_if.stage                   pc,
    input  rv32i_pkg::control_word       de_cw,
    input  logic [rv32i_pkg::XLEN-1:0]   rs1_val,
    input  logic [rv32i_pkg::XLEN-1:0]   rs2_val,
    input  logic [rv32i_pkg::XLEN-1:0]   imm,
    input  logic [rv32i_pkg::REG_AW-1:0] rd,
    output logic [rv32i_pkg::XLEN-1:0]   alu_out,
    output logic [rv32i_pkg::XLEN-1:0]   store_data,
    output logic [rv32i_pkg::REG_AW-1:0] ex_rd,
    output rv32i_pkg::control_word       ex_cw
);
    import rv32i_pkg::*;

    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] result;
    logic            exe_rdy_q;

    // loads and stores use the immediate as address offset
    assign op_b = de_cw.use_imm ? imm : rs2_val;

    always_comb begin
        case (de_cw.alu_op)
            alu_sub: result = rs1_val - op_b;
            alu_and: result = rs1_val & op_b;
            alu_or:  result = rs1_val | op_b;
            alu_xor: result = rs1_val ^ op_b;
            default: result = rs1_val + op_b;
        endcase
    end

    assign pc.exe_rdy = exe_rdy_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_cw     <= '0;
            exe_rdy_q <= 1'b0;
        end else if (pc.exe_go) begin
            ex_cw     <= de_cw;
            exe_rdy_q <= (de_cw.opcode != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (pc.exe_go) begin
            alu_out    <= result;
            store_data <= rs2_val;
            ex_rd      <= rd;
        end
    end

endmodule

`default_nettype wire

// File: source/fetch_stage.sv
/*
    Fetch stage
    program counter, instruction memory request and the fetch register
*/
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  logic                       clk,
    input  logic                       rst,
    pipe_ctrl_if.stage                 pc,
    output logic                       imem_read,
    output logic [rv32i_pkg::XLEN-1:0] imem_addr,
    input  logic [rv32i_pkg::XLEN-1:0] imem_rdata,
    input  logic                       imem_resp,
    output logic [rv32i_pkg::XLEN-1:0] instr
);
    import rv32i_pkg::*;

    logic [XLEN-1:0] pc_addr;
    logic            req;
    // word that came back while fetch was frozen
    logic            pend;
    logic [XLEN-1:0] pend_word;
    logic            if_rdy_q;

    assign imem_read = req;
    assign imem_addr = pc_addr;
    assign pc.if_rdy = if_rdy_q;

    // request side
    // address stays put until the pulse and the request drops the cycle after
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_addr <= '0;
            req     <= 1'b0;
        end else if (imem_resp) begin
            pc_addr <= pc_addr + XLEN'(4);
            req     <= 1'b0;
        end else if (!req && !pend && pc.if_go) begin
            // new requests only while the pipe moves
            req <= 1'b1;
        end
    end

    // fetch register, loads only on if_go
    always_ff @(posedge clk) begin
        if (rst) begin
            instr    <= NOP_WORD;
            if_rdy_q <= 1'b0;
            pend     <= 1'b0;
        end else if (pc.if_go) begin
            // with no word this edge decode gets a bubble next
            if_rdy_q <= imem_resp || pend;
            pend     <= 1'b0;
            if (pend) begin
                instr <= pend_word;
            end else if (imem_resp) begin
                instr <= imem_rdata;
            end
        end else if (imem_resp) begin
            pend <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (imem_resp && !pc.if_go) begin
            pend_word <= imem_rdata;
        end
    end

endmodule

`default_nettype wire

// File: source/memory_stage.sv
/*
    Memory stage
    data memory request held from the execute register, load select,
    and the memory register toward writeback
*/
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
    input  logic                         clk,
    input  logic                         rst,
    pipe_ctrl_if.stage                   pc,
    input  logic [rv32i_pkg::XLEN-1:0]   alu_out,
    input  logic [rv32i_pkg::XLEN-1:0]   store_data,
    input  logic [rv32i_pkg::REG_AW-1:0] ex_rd,
    input  rv32i_pkg::control_word       ex_cw,
    output logic                         dmem_read,
    output logic                         dmem_write,
    output logic [rv32i_pkg::XLEN-1:0]   dmem_addr,
    output logic [rv32i_pkg::XLEN-1:0]   dmem_wdata,
    input  logic [rv32i_pkg::XLEN-1:0]   dmem_rdata,
    input  logic                         dmem_resp,
    output logic [rv32i_pkg::REG_AW-1:0] wb_rd,
    output logic [rv32i_pkg::XLEN-1:0]   wb_data,
    output logic                         wb_write
);
    import rv32i_pkg::*;

    logic busy;
    // response seen while execute still holds the access
    logic done;
    logic capture;
    logic mem_rdy_q;

    // execute is frozen during the access, so address and data hold
    assign busy       = (ex_cw.mem_read || ex_cw.mem_write) && !done;
    assign dmem_read  = ex_cw.mem_read && !done;
    assign dmem_write = ex_cw.mem_write && !done;
    assign dmem_addr  = alu_out;
    assign dmem_wdata = store_data;

    assign pc.dmem_busy = busy;
    assign pc.mem_rdy   = mem_rdy_q;

    // load data on the pulse and the ALU result otherwise
    assign capture = pc.mem_go && (busy ? dmem_resp : !done);

    always_ff @(posedge clk) begin
        if (rst) begin
            done      <= 1'b0;
            mem_rdy_q <= 1'b0;
        end else if (pc.mem_go) begin
            if (busy) begin
                mem_rdy_q <= dmem_resp;
                done      <= dmem_resp;
            end else if (done) begin
                // access already passed on so drop the stale copy
                mem_rdy_q <= 1'b0;
                done      <= 1'b0;
            end else begin
                mem_rdy_q <= (ex_cw.opcode != '0);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            wb_rd    <= ex_rd;
            wb_data  <= ex_cw.mem_read ? dmem_rdata : alu_out;
            wb_write <= ex_cw.reg_write;
        end
    end

endmodule

`default_nettype wire

// File: source/pipe_control.sv
/*
    Pipeline controller
    go levels from the stage ready levels and the data memory stall,
    plus the control word for the instruction sitting in fetch
*/
`timescale 1ns/1ps
`default_nettype none

module pipe_control (
    input  logic                   clk,
    input  logic                   rst,
    pipe_ctrl_if.ctrl              ctrl,
    input  rv32i_pkg::rv32i_opcode opcode,
    input  logic [2:0]             funct3,
    input  logic [6:0]             funct7,
    output rv32i_pkg::control_word cw
);
    import rv32i_pkg::*;

    logic cw_en;

    function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic sub);
        alu_op_t op;
        case (f3)
            3'b000:  op = sub ? alu_sub : alu_add;
            3'b100:  op = alu_xor;
            3'b110:  op = alu_or;
            3'b111:  op = alu_and;
            default: op = alu_add;
        endcase
        return op;
    endfunction

    // a data access freezes everything above memory
    // a stage only moves with work upstream or a register to drain
    assign ctrl.if_go  = !ctrl.dmem_busy;
    assign ctrl.de_go  = !ctrl.dmem_busy && (ctrl.if_rdy || ctrl.de_rdy);
    assign ctrl.exe_go = !ctrl.dmem_busy && (ctrl.de_rdy || ctrl.exe_rdy);
    // memory keeps going while its access is open
    assign ctrl.mem_go = ctrl.dmem_busy || ctrl.exe_rdy || ctrl.mem_rdy;
    assign ctrl.wb_go  = ctrl.mem_rdy;

    // low through reset and the cycle after
    always_ff @(posedge clk) begin
        if (rst) begin
            cw_en <= 1'b0;
        end else begin
            cw_en <= 1'b1;
        end
    end

    always_comb begin
        // bubble unless fetch holds a live word
        cw = '0;
        if (cw_en && ctrl.if_rdy) begin
            cw.opcode = opcode;
            cw.funct3 = funct3;
            cw.funct7 = funct7;
            case (opcode)
                op_imm: begin
                    cw.alu_op    = alu_sel(funct3, 1'b0);
                    cw.reg_write = 1'b1;
                    cw.use_imm   = 1'b1;
                end
                op_reg: begin
                    // funct7 bit 5 picks sub over add
                    cw.alu_op    = alu_sel(funct3, funct7[5]);
                    cw.reg_write = 1'b1;
                end
                op_load: begin
                    cw.reg_write = 1'b1;
                    cw.mem_read  = 1'b1;
                    cw.use_imm   = 1'b1;
                end
                op_store: begin
                    cw.mem_write = 1'b1;
                    cw.use_imm   = 1'b1;
                end
                // unsupported opcode passes as a bubble
                default: cw = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/pipe_ctrl_if.sv
/*
    Pipeline control bundle
    ready levels up to the controller, go levels back down to the stages
*/
`timescale 1ns/1ps
`default_nettype none

interface pipe_ctrl_if;

    // stage register holds a live instruction
    logic if_rdy;
    logic de_rdy;
    logic exe_rdy;
    logic mem_rdy;
    logic wb_rdy;

    // stage may load its register on this edge
    logic if_go;
    logic de_go;
    logic exe_go;
    logic mem_go;
    logic wb_go;

    // data access waiting on its response
    logic dmem_busy;

    modport stage (
        output if_rdy, de_rdy, exe_rdy, mem_rdy, wb_rdy, dmem_busy,
        input  if_go, de_go, exe_go, mem_go, wb_go
    );

    modport ctrl (
        input  if_rdy, de_rdy, exe_rdy, mem_rdy, wb_rdy, dmem_busy,
        output if_go, de_go, exe_go, mem_go, wb_go
    );

endinterface

`default_nettype wire

// File: source/rv32i_pkg.sv
/*
    RV32I shared definitions
    widths, major opcodes, ALU operations and the pipeline control word
*/
`default_nettype none

package rv32i_pkg;

    // datapath and register file sizes
    localparam int XLEN      = 32;
    localparam int REG_COUNT = 32;
    localparam int REG_AW    = $clog2(REG_COUNT);

    // addi x0, x0, 0
    localparam logic [XLEN-1:0] NOP_WORD = 32'h0000_0013;

    // major opcodes handled by this core
    typedef enum logic [6:0] {
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011
    } rv32i_opcode;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4
    } alu_op_t;

    // 24 bits
    // all zero is a bubble since a live word never has opcode 0
    typedef struct packed {
        logic [6:0] opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        alu_op_t    alu_op;
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
        logic       use_imm;
    } control_word;

endpackage

`default_nettype wire

// File: verif/cpu_mem_model.sv
/*
    Memory model for one port of the core
    256 words, request held until a one-cycle response pulse,
    response latency drawn at random from 1 to 4 cycles
*/
`timescale 1ns/1ps
`default_nettype none

module cpu_mem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic        read,
    input  logic        write,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata,
    output logic        resp
);

    // word array loaded by the testbench through the hierarchy
    logic [31:0] mem [256];
    logic        busy;
    int          left;

    initial begin
        resp  = 1'b0;
        rdata = '0;
        busy  = 1'b0;
        left  = 0;
        forever begin
            @(posedge clk);
            // outputs change just after the edge, request already settled
            #2;
            if (rst || resp) begin
                // the core drops its request the cycle after the pulse
                resp = 1'b0;
                busy = 1'b0;
            end else if (read || write) begin
                if (!busy) begin
                    busy = 1'b1;
                    left = $urandom_range(4, 1);
                end
                left = left - 1;
                if (left == 0) begin
                    busy = 1'b0;
                    resp = 1'b1;
                    if (write) begin
                        mem[addr[9:2]] = wdata;
                    end else begin
                        rdata = mem[addr[9:2]];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/cpu_tb.sv
/*
    Testbench for the RV32I pipeline
    runs short programs from a table and checks every data store
    against the expected address and value
*/
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
    import rv32i_pkg::*;

    localparam int MAX_ROWS  = 8;
    localparam int MAX_WORDS = 16;
    localparam int MAX_ST    = 8;
    localparam int MAX_LAT   = 4;
    // cycles watched after the last store for any extra one
    localparam int SETTLE    = 20;

    logic        clk;
    logic        rst;
    logic        imem_read;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic        imem_resp;
    logic        dmem_read;
    logic        dmem_write;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic [31:0] dmem_rdata;
    logic        dmem_resp;

    // program table
    logic [31:0] prog    [MAX_ROWS][MAX_WORDS];
    int          plen    [MAX_ROWS];
    int          nst     [MAX_ROWS];
    logic [31:0] st_addr [MAX_ROWS][MAX_ST];
    logic [31:0] st_data [MAX_ROWS][MAX_ST];
    int          nrows;

    int errors;
    int cur_row;
    int store_idx;
    int cycles;
    int limit;

    cpu_top dut (
        .clk        (clk),
        .rst        (rst),
        .imem_read  (imem_read),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .imem_resp  (imem_resp),
        .dmem_read  (dmem_read),
        .dmem_write (dmem_write),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .dmem_resp  (dmem_resp)
    );

    cpu_mem_model imem_model (
        .clk   (clk),
        .rst   (rst),
        .read  (imem_read),
        .write (1'b0),
        .addr  (imem_addr),
        .wdata (32'h0),
        .rdata (imem_rdata),
        .resp  (imem_resp)
    );

    cpu_mem_model dmem_model (
        .clk   (clk),
        .rst   (rst),
        .read  (dmem_read),
        .write (dmem_write),
        .addr  (dmem_addr),
        .wdata (dmem_wdata),
        .rdata (dmem_rdata),
        .resp  (dmem_resp)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // instruction encoders in the RV32I field layout
    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lw(input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                       input logic [11:0] imm);
        // offset split around the source fields
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] rop(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    task automatic add_word(input logic [31:0] w);
        prog[nrows][plen[nrows]] = w;
        plen[nrows] = plen[nrows] + 1;
    endtask

    // without forwarding a consumer sits four slots behind its producer
    task automatic add_gap();
        for (int i = 0; i < 4; i++) begin
            add_word(NOP_WORD);
        end
    endtask

    task automatic expect_store(input logic [31:0] a, input logic [31:0] d);
        st_addr[nrows][nst[nrows]] = a;
        st_data[nrows][nst[nrows]] = d;
        nst[nrows] = nst[nrows] + 1;
    endtask

    task automatic build_table();
        for (int r = 0; r < MAX_ROWS; r++) begin
            plen[r] = 0;
            nst[r]  = 0;
        end
        nrows = 0;
        // addi then store
        add_word(addi(5'd1, 5'd0, 12'h123));
        add_gap();
        add_word(sw(5'd1, 5'd0, 12'h040));
        expect_store(32'h40, 32'h0000_0123);
        nrows++;
        // add, sub, and on 100 and -7
        add_word(addi(5'd1, 5'd0, 12'd100));
        add_word(addi(5'd2, 5'd0, 12'hff9));
        add_gap();
        add_word(rop(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
        add_word(rop(7'h20, 3'b000, 5'd4, 5'd1, 5'd2));
        add_word(rop(7'h00, 3'b111, 5'd5, 5'd1, 5'd2));
        add_gap();
        add_word(sw(5'd3, 5'd0, 12'h050));
        add_word(sw(5'd4, 5'd0, 12'h054));
        add_word(sw(5'd5, 5'd0, 12'h058));
        // 93, 107 and 0x64 masked by 0xf9
        expect_store(32'h50, 32'h0000_005d);
        expect_store(32'h54, 32'h0000_006b);
        expect_store(32'h58, 32'h0000_0060);
        nrows++;
        // or, xor on the same values
        add_word(addi(5'd1, 5'd0, 12'd100));
        add_word(addi(5'd2, 5'd0, 12'hff9));
        add_gap();
        add_word(rop(7'h00, 3'b110, 5'd6, 5'd1, 5'd2));
        add_word(rop(7'h00, 3'b100, 5'd7, 5'd1, 5'd2));
        add_gap();
        add_word(sw(5'd6, 5'd0, 12'h05c));
        add_word(sw(5'd7, 5'd0, 12'h060));
        expect_store(32'h5c, 32'hffff_fffd);
        expect_store(32'h60, 32'hffff_ff9d);
        nrows++;
        // load 17 from ram, add 16, store
        add_word(lw(5'd1, 5'd0, 12'h080));
        add_word(addi(5'd2, 5'd0, 12'd16));
        add_gap();
        add_word(rop(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
        add_gap();
        add_word(sw(5'd3, 5'd0, 12'h084));
        expect_store(32'h84, 32'd33);
        nrows++;
        // back to back stores where order and count matter
        add_word(addi(5'd1, 5'd0, 12'h011));
        add_word(addi(5'd2, 5'd0, 12'h022));
        add_word(addi(5'd3, 5'd0, 12'h033));
        add_gap();
        add_word(sw(5'd1, 5'd0, 12'h100));
        add_word(sw(5'd2, 5'd0, 12'h104));
        add_word(sw(5'd3, 5'd0, 12'h108));
        add_word(sw(5'd1, 5'd0, 12'h10c));
        add_word(sw(5'd2, 5'd0, 12'h110));
        expect_store(32'h100, 32'h11);
        expect_store(32'h104, 32'h22);
        expect_store(32'h108, 32'h33);
        expect_store(32'h10c, 32'h11);
        expect_store(32'h110, 32'h22);
        nrows++;
        // x0 ignores writes
        add_word(addi(5'd0, 5'd0, 12'h055));
        add_gap();
        add_word(sw(5'd0, 5'd0, 12'h020));
        expect_store(32'h20, 32'h0);
        nrows++;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h (row %0d store %0d)",
                     name, got, exp, cur_row, store_idx);
            errors++;
        end
    endtask

    task automatic load_memories(input int r);
        for (int i = 0; i < 256; i++) begin
            imem_model.mem[i] = (i < plen[r]) ? prog[r][i] : NOP_WORD;
            // ram fill tracks the byte address
            dmem_model.mem[i] = 32'hd000_0000 | 32'(i << 2);
        end
        dmem_model.mem[32] = 32'd17;
    endtask

    // stores are stable from just after the edge, so look at the falling edge
    always @(negedge clk) begin
        if (!rst && dmem_write && dmem_resp) begin
            if (store_idx < nst[cur_row]) begin
                check_value("dmem_addr", dmem_addr, st_addr[cur_row][store_idx]);
                check_value("dmem_wdata", dmem_wdata, st_data[cur_row][store_idx]);
            end else begin
                $display("row %0d made a store that the program does not hold, addr %h",
                         cur_row, dmem_addr);
                errors++;
            end
            store_idx++;
        end
    end

    initial begin
        rst       = 1'b1;
        errors    = 0;
        cur_row   = 0;
        store_idx = 0;
        void'($urandom(32'hc3e6));
        build_table();
        for (int r = 0; r < nrows; r++) begin
            @(posedge clk);
            #2;
            rst       = 1'b1;
            cur_row   = r;
            store_idx = 0;
            load_memories(r);
            repeat (3) @(posedge clk);
            #2;
            // every memory request is down while reset holds
            check_value("imem_read", 32'(imem_read), 32'h0);
            check_value("dmem_read", 32'(dmem_read), 32'h0);
            check_value("dmem_write", 32'(dmem_write), 32'h0);
            rst    = 1'b0;
            cycles = 0;
            limit  = 64 * plen[r] * MAX_LAT;
            while (store_idx < nst[r]) begin
                @(posedge clk);
                cycles++;
                if (cycles >= limit) begin
                    $display("row %0d timed out after %0d cycles, %0d of %0d stores seen",
                             r, cycles, store_idx, nst[r]);
                    $display("errors: %0d", errors + 1);
                    $display("CHECKS FAILED");
                    $finish;
                end
            end
            // duplicates would show up here as extra stores
            repeat (SETTLE) @(posedge clk);
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
